// ==== list.f ====
logic/ahb_bus_pkg.sv
logic/ahb_map_pkg.sv
logic/ahb_master_mux.sv
logic/ahb_slave_decode.sv
logic/ahb_shared_bus.sv
verif/ahb_bus_properties.sv
verif/ahb_bus_tb.sv

// ==== logic/ahb_bus_pkg.sv ====
package ahb_bus_pkg;

  ////////////////////////////////////////
  // Field types
  ////////////////////////////////////////

  // Bus address and data word, fixed at 32 bits
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Transfer type, same encoding as on the bus
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef logic [2:0] hsize_t;
  typedef logic [2:0] hburst_t;
  typedef logic [3:0] hprot_t;

  // Single bit response code
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  ////////////////////////////////////////
  // Request and response bundles
  ////////////////////////////////////////

  // Master to bus, bus to slave
  typedef struct packed {
    logic     hsel;
    addr_t    haddr;
    data_t    hwdata;
    logic     hwrite;
    hsize_t   hsize;
    hburst_t  hburst;
    hprot_t   hprot;
    htrans_e  htrans;
    logic     hmastlock;
  } ahb_req_t;

  // Slave to bus, bus to master
  typedef struct packed {
    data_t hrdata;
    logic  hready;
    logic  hresp;
  } ahb_rsp_t;

  // All zero request is an unselected IDLE transfer
  localparam ahb_req_t REQ_IDLE = '0;

  // NONSEQ and SEQ carry a real transfer
  function automatic logic trans_active(htrans_e htrans);
    return (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
  endfunction

endpackage

// ==== logic/ahb_map_pkg.sv ====
package ahb_map_pkg;

  import ahb_bus_pkg::*;

  // Region hit when the masked address equals the base
  typedef struct packed {
    addr_t base;
    addr_t mask;
  } region_t;

  // Map array size limit
  localparam int MAX_SLAVES = 8;

  // Never matches, fills unused map entries
  localparam region_t NO_REGION = '{base: 32'hFFFF_FFFF, mask: 32'h0000_0000};

  // Two 4 KiB windows
  localparam region_t REGION_S0 = '{base: 32'h0000_0000, mask: 32'hFFFF_F000};
  localparam region_t REGION_S1 = '{base: 32'h0001_0000, mask: 32'hFFFF_F000};

  // Entry 0 sits at the low end
  localparam region_t [MAX_SLAVES-1:0] DEFAULT_MAP =
    {{(MAX_SLAVES-2){NO_REGION}}, REGION_S1, REGION_S0};

  function automatic logic addr_in_region(addr_t addr, region_t region);
    return (addr & region.mask) == region.base;
  endfunction

endpackage

// ==== logic/ahb_master_mux.sv ====
`timescale 1ns/1ps

module ahb_master_mux import ahb_bus_pkg::*; #(
  parameter int MASTERS = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_i,

  // Master side
  input  ahb_req_t [MASTERS-1:0]   m_req_i,
  output ahb_rsp_t [MASTERS-1:0]   m_rsp_o,

  // Shared bus side
  output ahb_req_t                 bus_req_o,
  input  ahb_rsp_t                 bus_rsp_i,

  // Outside agent takes the idle bus
  input  logic                     bus_hold_i,
  output logic                     bus_hold_ack_o
);

  localparam int IDX_W = (MASTERS > 1) ? $clog2(MASTERS) : 1;

  typedef logic [IDX_W-1:0] mst_idx_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_OWNED,
    ARB_HELD
  } arb_state_e;

  arb_state_e           state_q, state_d;
  logic [MASTERS-1:0]   grant_q, grant_d;
  mst_idx_t             last_q, last_d;
  logic                 data_pend_q;

  mst_idx_t             win_idx;
  logic                 win_vld;
  logic                 owner_busy;
  logic                 addr_acc;
  logic                 switch_ok;

  ////////////////////////////////////////
  // Bus multiplexing
  ////////////////////////////////////////

  // AND-OR mux on the one-hot grant, zero grant gives an idle bus
  always_comb begin
    bus_req_o = REQ_IDLE;
    for (int i = 0; i < MASTERS; i++) begin
      bus_req_o = bus_req_o | (m_req_i[i] & {$bits(ahb_req_t){grant_q[i]}});
    end
  end

  // Shared read data and response, hready only to the owner
  // Everyone else waits with hready low
  always_comb begin
    for (int i = 0; i < MASTERS; i++) begin
      m_rsp_o[i].hrdata = bus_rsp_i.hrdata;
      m_rsp_o[i].hresp  = bus_rsp_i.hresp;
      m_rsp_o[i].hready = bus_rsp_i.hready & grant_q[i];
    end
  end

  ////////////////////////////////////////
  // Round-robin arbitration
  ////////////////////////////////////////

  // First requester after the last owner, wrapping around
  always_comb begin
    int cand;
    win_vld = 1'b0;
    win_idx = last_q;
    for (int k = 1; k <= MASTERS; k++) begin
      cand = (int'(last_q) + k) % MASTERS;
      if (!win_vld && m_req_i[cand].hsel && trans_active(m_req_i[cand].htrans)) begin
        win_vld = 1'b1;
        win_idx = mst_idx_t'(cand);
      end
    end
  end

  // Owner still in an address phase or a burst
  assign owner_busy = bus_req_o.hsel && (bus_req_o.htrans != HTRANS_IDLE);
  assign addr_acc   = bus_req_o.hsel && trans_active(bus_req_o.htrans) && bus_rsp_i.hready;

  // Free to re-arbitrate once the last data phase ends this edge
  assign switch_ok = !owner_busy && !bus_req_o.hmastlock &&
                     (!data_pend_q || bus_rsp_i.hready);

  always_comb begin
    state_d = state_q;
    grant_d = grant_q;
    last_d  = last_q;
    if (switch_ok) begin
      if (bus_hold_i) begin
        // Hand the bus to the outside agent
        state_d = ARB_HELD;
        grant_d = '0;
      end else if (win_vld) begin
        // Direct owner change, no idle cycle in between
        state_d = ARB_OWNED;
        grant_d = MASTERS'(1) << win_idx;
        last_d  = win_idx;
      end else begin
        state_d = ARB_IDLE;
        grant_d = '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= ARB_IDLE;
      grant_q     <= '0;
      // Master 0 wins first
      last_q      <= mst_idx_t'(MASTERS - 1);
      data_pend_q <= 1'b0;
    end else begin
      state_q <= state_d;
      grant_q <= grant_d;
      last_q  <= last_d;
      // Data phase pending until an edge with hready high
      if (bus_rsp_i.hready) begin
        data_pend_q <= addr_acc;
      end
    end
  end

  assign bus_hold_ack_o = (state_q == ARB_HELD);

endmodule

// ==== logic/ahb_shared_bus.sv ====
`timescale 1ns/1ps

module ahb_shared_bus import ahb_bus_pkg::*; import ahb_map_pkg::*; #(
  parameter int                          MASTERS   = 2,
  parameter int                          SLAVES    = 2,
  parameter region_t [MAX_SLAVES-1:0]    SLAVE_MAP = DEFAULT_MAP
) (
  input  logic                     clk_i,
  input  logic                     rst_i,

  // Masters
  input  ahb_req_t [MASTERS-1:0]   m_req_i,
  output ahb_rsp_t [MASTERS-1:0]   m_rsp_o,

  // Slaves
  output ahb_req_t [SLAVES-1:0]    s_req_o,
  input  ahb_rsp_t [SLAVES-1:0]    s_rsp_i,

  // Accepted write addresses, one cycle each
  output addr_t                    snoop_adr_o,
  output logic                     snoop_en_o,

  input  logic                     bus_hold_i,
  output logic                     bus_hold_ack_o
);

  // Single shared bus between arbiter and decoder
  ahb_req_t bus_req;
  ahb_rsp_t bus_rsp;

  ahb_master_mux #(
    .MASTERS(MASTERS)
  ) u_mux (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .m_req_i       (m_req_i),
    .m_rsp_o       (m_rsp_o),
    .bus_req_o     (bus_req),
    .bus_rsp_i     (bus_rsp),
    .bus_hold_i    (bus_hold_i),
    .bus_hold_ack_o(bus_hold_ack_o)
  );

  ahb_slave_decode #(
    .SLAVES   (SLAVES),
    .SLAVE_MAP(SLAVE_MAP)
  ) u_decode (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .bus_req_i(bus_req),
    .bus_rsp_o(bus_rsp),
    .s_req_o  (s_req_o),
    .s_rsp_i  (s_rsp_i)
  );

  ////////////////////////////////////////
  // Snoop port
  ////////////////////////////////////////

  // Address straight off the bus
  assign snoop_adr_o = bus_req.haddr;
  // Write address phase accepted this cycle, mapped or not
  assign snoop_en_o  = bus_req.hsel && trans_active(bus_req.htrans) &&
                       bus_req.hwrite && bus_rsp.hready;

endmodule

// ==== logic/ahb_slave_decode.sv ====
`timescale 1ns/1ps

module ahb_slave_decode import ahb_bus_pkg::*; import ahb_map_pkg::*; #(
  parameter int                          SLAVES    = 2,
  parameter region_t [MAX_SLAVES-1:0]    SLAVE_MAP = DEFAULT_MAP
) (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Shared bus side
  input  ahb_req_t                bus_req_i,
  output ahb_rsp_t                bus_rsp_o,

  // Slave side
  output ahb_req_t [SLAVES-1:0]   s_req_o,
  input  ahb_rsp_t [SLAVES-1:0]   s_rsp_i
);

  localparam int SIDX_W = (SLAVES > 1) ? $clog2(SLAVES) : 1;

  typedef logic [SIDX_W-1:0] slv_idx_t;

  // Default slave for unmapped addresses
  typedef enum logic [1:0] {
    DFLT_OK,
    DFLT_ERR1,
    DFLT_ERR2
  } dflt_state_e;

  dflt_state_e  dflt_q, dflt_d;
  ahb_rsp_t     dflt_rsp;

  logic         hit;
  slv_idx_t     hit_idx;
  logic         acc;

  // Data phase target
  logic         dp_map_q;
  slv_idx_t     dp_slv_q;

  ////////////////////////////////////////
  // Address phase decode
  ////////////////////////////////////////

  // First matching region wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int s = 0; s < SLAVES; s++) begin
      if (!hit && addr_in_region(bus_req_i.haddr, SLAVE_MAP[s])) begin
        hit     = 1'b1;
        hit_idx = slv_idx_t'(s);
      end
    end
  end

  assign acc = bus_req_i.hsel && trans_active(bus_req_i.htrans) && bus_rsp_o.hready;

  // Request broadcast, hsel only to the hit slave
  // Slaves have no hready input, so hsel also waits for a free bus
  always_comb begin
    for (int s = 0; s < SLAVES; s++) begin
      s_req_o[s]      = bus_req_i;
      s_req_o[s].hsel = bus_req_i.hsel && hit && (hit_idx == slv_idx_t'(s)) &&
                        bus_rsp_o.hready;
    end
  end

  ////////////////////////////////////////
  // Data phase and response
  ////////////////////////////////////////

  // Two cycle ERROR, OKAY with no wait otherwise
  always_comb begin
    dflt_d = dflt_q;
    case (dflt_q)
      DFLT_OK: begin
        if (acc && !hit) begin
          dflt_d = DFLT_ERR1;
        end
      end
      DFLT_ERR1: dflt_d = DFLT_ERR2;
      // Back-to-back unmapped transfer restarts the error
      DFLT_ERR2: dflt_d = (acc && !hit) ? DFLT_ERR1 : DFLT_OK;
      default:   dflt_d = DFLT_OK;
    endcase
  end

  always_comb begin
    dflt_rsp.hrdata = '0;
    dflt_rsp.hready = (dflt_q != DFLT_ERR1);
    dflt_rsp.hresp  = (dflt_q == DFLT_OK) ? HRESP_OKAY : HRESP_ERROR;
    // A stalling slave stalls the whole bus
    bus_rsp_o = dp_map_q ? s_rsp_i[dp_slv_q] : dflt_rsp;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dflt_q   <= DFLT_OK;
      dp_map_q <= 1'b0;
    end else begin
      dflt_q <= dflt_d;
      if (bus_rsp_o.hready) begin
        dp_map_q <= acc && hit;
      end
    end
  end

  // Slave index of the data phase
  always_ff @(posedge clk_i) begin
    if (acc) begin
      dp_slv_q <= hit_idx;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module ahb_bus_tb \
  -f list.f -o sim_tb && \
  ./obj_dir/sim_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" && \
  echo "run_sim: PASS" || { echo "run_sim: FAIL"; exit 1; }

// ==== verif/ahb_bus_properties.sv ====
`timescale 1ns/1ps

module ahb_bus_properties import ahb_bus_pkg::*; #(
  parameter int MASTERS = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [MASTERS-1:0]   grant_q,
  input  ahb_req_t             bus_req_o,
  input  logic                 bus_hold_ack_o
);

  // At most one master owns the bus
  grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(grant_q))
    else $error("grant is not one-hot or zero");

  // Held bus carries no transfer
  hold_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_hold_ack_o |-> (!bus_req_o.hsel && bus_req_o.htrans == HTRANS_IDLE))
    else $error("bus not idle while hold is acknowledged");

  // Locked owner keeps the bus
  lock_keeps_owner: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_req_o.hmastlock |=> $stable(grant_q))
    else $error("owner changed while hmastlock was set");

endmodule

bind ahb_master_mux ahb_bus_properties #(.MASTERS(MASTERS)) u_props (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .grant_q       (grant_q),
  .bus_req_o     (bus_req_o),
  .bus_hold_ack_o(bus_hold_ack_o)
);

// ==== verif/ahb_bus_tb.sv ====
`timescale 1ns/1ps

module ahb_bus_tb import ahb_bus_pkg::*, ahb_map_pkg::*; #(
  parameter int N_XFERS = 200
);

  localparam int TIMEOUT_NS = 2 * N_XFERS * 20 * 10;

  logic clk_i, rst_i, bus_hold_i, bus_hold_ack_o, snoop_en_o;
  addr_t snoop_adr_o;
  ahb_req_t [1:0] m_req, s_req;
  ahb_rsp_t [1:0] m_rsp, s_rsp;

  integer seed = 32'he9ee;
  // Slave memories and the reference memory, keyed by address
  data_t slv_mem [addr_t];
  data_t ref_mem [addr_t];
  // Slave model state
  logic s_busy [2];
  logic s_wr [2];
  addr_t s_adr [2];
  int s_wait [2];
  // Arbitration tracking
  int prev_win = -1;
  logic prev_lock = 1'b0;
  logic waiting [2] = '{1'b0, 1'b0};

  ahb_shared_bus #(
    .MASTERS(2), .SLAVES(2), .SLAVE_MAP(DEFAULT_MAP)
  ) dut_i (
    .clk_i(clk_i), .rst_i(rst_i), .m_req_i(m_req), .m_rsp_o(m_rsp),
    .s_req_o(s_req), .s_rsp_i(s_rsp), .snoop_adr_o(snoop_adr_o),
    .snoop_en_o(snoop_en_o), .bus_hold_i(bus_hold_i), .bus_hold_ack_o(bus_hold_ack_o)
  );

  ////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////

  // Unwritten words read back a pattern of the whole address
  function automatic data_t fill_word(addr_t a);
    return a ^ 32'hA5C3_5A3C;
  endfunction

  // Expected slave from the memory map, -1 when unmapped
  function automatic int slave_of(addr_t a);
    if (a[31:12] == 20'h00000) return 0;
    if (a[31:12] == 20'h00010) return 1;
    return -1;
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // Clock, slave models, bus monitor
  ////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Memories with 0 to 2 wait states, sampled at the edge and driven 1 ns later
  always @(posedge clk_i) begin
    for (int s = 0; s < 2; s++) begin
      if (s_busy[s] && s_rsp[s].hready) begin
        if (s_wr[s]) slv_mem[s_adr[s]] = s_req[s].hwdata;
        s_busy[s] = 1'b0;
      end
      if (!rst_i && s_req[s].hsel && s_req[s].htrans == HTRANS_NONSEQ) begin
        s_busy[s] = 1'b1;
        s_adr[s] = s_req[s].haddr;
        s_wr[s] = s_req[s].hwrite;
        s_wait[s] = $unsigned($random(seed)) % 3;
      end
    end
    #1;
    for (int s = 0; s < 2; s++) begin
      s_rsp[s] = '{hrdata: '0, hready: 1'b1, hresp: HRESP_OKAY};
      if (s_busy[s] && s_wait[s] > 0) begin
        s_rsp[s].hready = 1'b0;
        s_wait[s]--;
      end else if (s_busy[s] && !s_wr[s]) begin
        s_rsp[s].hrdata = slv_mem.exists(s_adr[s]) ? slv_mem[s_adr[s]] : fill_word(s_adr[s]);
      end
    end
  end

  // Routing, snoop, hold and arbitration checks on every edge
  always @(posedge clk_i) begin
    int win;
    int hits;
    win = -1;
    hits = 0;
    if (!rst_i) begin
      for (int i = 0; i < 2; i++) begin
        if (m_req[i].hsel && m_req[i].htrans == HTRANS_NONSEQ && m_rsp[i].hready) win = i;
      end
      for (int s = 0; s < 2; s++) begin
        if (s_req[s].hsel) begin
          hits++;
          if (win < 0) stop_on_error("A slave was selected with no accepted transfer");
          if (slave_of(m_req[win].haddr) != s) stop_on_error("Transfer routed to the wrong slave");
          check_addr("s_req_o.haddr", s_req[s].haddr, m_req[win].haddr);
          if (s_req[s].hwrite !== m_req[win].hwrite || s_req[s].hsize !== m_req[win].hsize)
            stop_on_error("Slave saw the wrong direction or size");
        end
      end
      if (win >= 0 && slave_of(m_req[win].haddr) >= 0 && hits != 1)
        stop_on_error("Mapped transfer did not reach exactly one slave");
      check_resp("snoop_en_o", snoop_en_o, win >= 0 && m_req[win].hwrite);
      if (snoop_en_o) check_addr("snoop_adr_o", snoop_adr_o, m_req[win].haddr);
      if (bus_hold_ack_o && (hits != 0 || m_rsp[0].hready || m_rsp[1].hready))
        stop_on_error("Bus activity while the hold was acknowledged");
      if (win >= 0) begin
        if (win == prev_win && waiting[1-win] && !prev_lock)
          stop_on_error("A master won twice in a row while the other waited");
        waiting[win] = 1'b0;
        waiting[1-win] = m_req[1-win].hsel && m_req[1-win].htrans == HTRANS_NONSEQ;
        prev_win = win;
        prev_lock = m_req[win].hmastlock;
      end
    end
  end

  ////////////////////////////////////////
  // Masters, hold agent, main flow
  ////////////////////////////////////////

  // Single transfers, NONSEQ then IDLE, about one in ten unmapped
  // Roughly one in sixteen holds hmastlock through its data phase
  task automatic run_master(int m);
    int r;
    addr_t a;
    data_t wd;
    data_t exp;
    logic wr;
    logic lk;
    ahb_req_t req;
    for (int n = 0; n < N_XFERS; n++) begin
      r = $random(seed);
      a = addr_t'($random(seed)) & 32'h0000_00FC;
      if ((r & 255) < 26) a = a | 32'h0002_0000;
      else if (r[8]) a = a | 32'h0001_0000;
      wr = r[9];
      lk = (r[15:12] == 4'h0);
      wd = $random(seed);
      req = '0;
      req.hsel = 1'b1;
      req.haddr = a;
      req.hwrite = wr;
      req.hsize = 3'b010;
      req.htrans = HTRANS_NONSEQ;
      req.hmastlock = lk;
      m_req[m] = req;
      @(posedge clk_i);
      while (!m_rsp[m].hready) @(posedge clk_i);
      // Data phase, write data follows the address
      #1;
      req = '0;
      req.hwdata = wd;
      req.hmastlock = lk;
      m_req[m] = req;
      @(posedge clk_i);
      while (!m_rsp[m].hready) @(posedge clk_i);
      check_resp("m_rsp_o.hresp", m_rsp[m].hresp, slave_of(a) < 0);
      if (slave_of(a) >= 0 && wr) begin
        ref_mem[a] = wd;
      end else if (slave_of(a) >= 0) begin
        exp = ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
        check_data("m_rsp_o.hrdata", m_rsp[m].hrdata, exp);
      end
      #1;
    end
    m_req[m] = '0;
  endtask

  // Takes the bus once in the middle of the traffic
  task automatic run_hold();
    int cnt;
    cnt = 0;
    repeat (150) @(posedge clk_i);
    #1 bus_hold_i = 1'b1;
    @(posedge clk_i);
    while (!bus_hold_ack_o) begin
      cnt++;
      if (cnt > 50) stop_on_error("Bus hold was never acknowledged");
      @(posedge clk_i);
    end
    repeat (20) @(posedge clk_i);
    #1 bus_hold_i = 1'b0;
  endtask

  initial begin
    m_req = '0;
    s_rsp = '0;
    bus_hold_i = 1'b0;
    s_busy = '{1'b0, 1'b0};
    rst_i = 1'b1;
    repeat (3) @(posedge clk_i);
    #1 rst_i = 1'b0;
    fork
      run_master(0);
      run_master(1);
      run_hold();
    join
    repeat (5) @(posedge clk_i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Watchdog over the whole run
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout, the transfers did not finish in time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule
